/* hdl/armPkg.sv */
package armPkg;

  // ==========================================================
  // AXI4-Lite master port
  // ==========================================================

  // Master to slave
  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
  } axiReqT;

  // Slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axiRspT;

  // One requester toward the arbiter
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } memReqT;

  // Done pulses for one cycle with the read word
  typedef struct packed {
    logic        done;
    logic [31:0] rdata;
  } memRspT;

  // ==========================================================
  // Instruction fields and decode constants
  // ==========================================================

  // Data-processing layout, also overlays LDR/STR and B
  typedef struct packed {
    logic [3:0]  cond;
    logic [2:0]  cls;
    logic [3:0]  opcode;
    logic        s;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } instrT;

  localparam logic [2:0] clsDpReg  = 3'b000;
  localparam logic [2:0] clsDpImm  = 3'b001;
  localparam logic [2:0] clsMem    = 3'b010;
  localparam logic [2:0] clsBranch = 3'b101;

  // ARM data-processing opcodes
  localparam logic [3:0] opAnd = 4'b0000;
  localparam logic [3:0] opSub = 4'b0010;
  localparam logic [3:0] opAdd = 4'b0100;
  localparam logic [3:0] opOrr = 4'b1100;
  localparam logic [3:0] opMov = 4'b1101;

  localparam logic [31:0] pcReset = 32'h0000_0000;

  // Forwarding selects for the E-stage operand muxes
  localparam logic [1:0] fwdReg = 2'b00;
  localparam logic [1:0] fwdWb  = 2'b01;
  localparam logic [1:0] fwdMem = 2'b10;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluMov
  } aluOpT;

  // Decoded controls, carried from D to W
  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memToReg;
    logic       aluSrcImm;
    logic       branch;
    aluOpT      aluOp;
    logic [3:0] rd;
    logic [3:0] rn;
    logic [3:0] rm;
  } ctrlT;

  // ==========================================================
  // Pipeline stage registers
  // ==========================================================
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instrT       instr;
  } decStageT;

  typedef struct packed {
    logic        valid;
    ctrlT        ctrl;
    logic [31:0] pcPlus8;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [23:0] imm24;
  } exeStageT;

  typedef struct packed {
    logic        valid;
    ctrlT        ctrl;
    logic [31:0] aluOut;
    logic [31:0] writeData;
  } memStageT;

  typedef struct packed {
    logic        valid;
    ctrlT        ctrl;
    logic [31:0] aluOut;
    logic [31:0] readData;
  } wbStageT;

endpackage

/* hdl/regFile.sv */
module regFile (
  input  logic        clk,
  input  logic        rstN,
  input  logic        we,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa,
  input  logic [31:0] wd,
  input  logic [31:0] pcPlus8,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [16];

  // Written at the clock edge that ends writeback
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // r15 reads as PC+8 of the decoding instruction
  // A same-cycle write is passed straight through to the reader
  assign rd1 = (ra1 == 4'd15) ? pcPlus8 : (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (ra2 == 4'd15) ? pcPlus8 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

/* hdl/alu.sv */
module alu (
  input  logic          [31:0] a,
  input  logic          [31:0] b,
  input  armPkg::aluOpT        op,
  input  logic          [11:0] imm12,
  input  logic                 useImm,
  output logic          [31:0] y
);
  import armPkg::*;

  logic [63:0] rotated;
  logic [31:0] immExp;
  logic [31:0] opB;

  // Rotated immediate
  // Two copies side by side turn the right shift into a rotate
  assign rotated = {2{24'h0, imm12[7:0]}} >> {imm12[11:8], 1'b0};
  assign immExp  = rotated[31:0];

  assign opB = useImm ? immExp : b;

  always_comb begin
    case (op)
      aluAdd: begin
        y = a + opB;
      end
      aluSub: begin
        y = a - opB;
      end
      aluAnd: begin
        y = a & opB;
      end
      aluOrr: begin
        y = a | opB;
      end
      aluMov: begin
        // MOV ignores the first operand
        y = opB;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

/* hdl/controller.sv */
module controller (
  input  logic         [31:0] instr,
  output armPkg::ctrlT        ctrl
);
  import armPkg::*;

  instrT f;

  assign f = instrT'(instr);

  // Condition field is ignored, every instruction executes
  always_comb begin
    ctrl = '0;
    case (f.cls)
      clsDpReg, clsDpImm: begin
        ctrl.rd        = f.rd;
        ctrl.rn        = f.rn;
        ctrl.rm        = f.operand2[3:0];
        ctrl.aluSrcImm = (f.cls == clsDpImm);
        ctrl.regWrite  = 1'b1;
        case (f.opcode)
          opAdd: begin
            ctrl.aluOp = aluAdd;
          end
          opSub: begin
            ctrl.aluOp = aluSub;
          end
          opAnd: begin
            ctrl.aluOp = aluAnd;
          end
          opOrr: begin
            ctrl.aluOp = aluOrr;
          end
          opMov: begin
            ctrl.aluOp = aluMov;
          end
          default: begin
            // Unsupported opcode becomes a no-op
            ctrl.regWrite = 1'b0;
          end
        endcase
        // No shifter, so a shifted register operand is dropped too
        if (f.cls == clsDpReg && f.operand2[11:4] != 8'h0) begin
          ctrl.regWrite = 1'b0;
        end
      end
      clsMem: begin
        // Base in rn, store data read through rm
        ctrl.rn = f.rn;
        ctrl.rm = f.rd;
        ctrl.rd = f.rd;
        // U bit picks add or subtract of the offset
        ctrl.aluOp = instr[23] ? aluAdd : aluSub;
        // Word access only, byte forms do nothing
        if (!instr[22]) begin
          if (instr[20]) begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
          end else begin
            ctrl.memWrite = 1'b1;
          end
        end
      end
      clsBranch: begin
        // Link bit not honored
        ctrl.branch = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* hdl/hazardUnit.sv */
module hazardUnit (
  input  logic [3:0] rnE,
  input  logic [3:0] rmE,
  input  logic [3:0] rdE,
  input  logic       memToRegE,
  input  logic [3:0] rdM,
  input  logic       regWriteM,
  input  logic [3:0] rdW,
  input  logic       regWriteW,
  input  logic [3:0] rnD,
  input  logic [3:0] rmD,
  input  logic       branchTakenE,
  input  logic       fetchWait,
  input  logic       dataWait,
  output logic       stallF,
  output logic       stallD,
  output logic       stallE,
  output logic       stallM,
  output logic       stallW,
  output logic       flushD,
  output logic       flushE,
  output logic [1:0] forwardA,
  output logic [1:0] forwardB
);
  import armPkg::*;

  logic memStall;
  logic loadUse;

  // Newest producer wins, r15 is never forwarded
  function automatic logic [1:0] fwdSel(input logic [3:0] src);
    if (regWriteM && rdM == src && src != 4'd15) begin
      return fwdMem;
    end
    if (regWriteW && rdW == src && src != 4'd15) begin
      return fwdWb;
    end
    return fwdReg;
  endfunction

  always_comb begin
    forwardA = fwdSel(rnE);
    forwardB = fwdSel(rmE);

    // Any outstanding bus access freezes the whole pipe
    memStall = fetchWait || dataWait;
    // Load in E feeding D waits one advance
    loadUse = memToRegE && (rdE == rnD || rdE == rmD);

    stallF = memStall || loadUse;
    stallD = memStall || loadUse;
    stallE = memStall;
    stallM = memStall;
    stallW = memStall;

    // Flushes only take effect on an advance
    flushD = branchTakenE && !memStall;
    flushE = (branchTakenE || loadUse) && !memStall;

    assert (!(flushE && stallE))
      else $error("hazardUnit flushE and stallE high together");
  end

endmodule

/* hdl/datapath.sv */
module datapath (
  input  logic           clk,
  input  logic           rstN,
  output armPkg::memReqT fetchReq,
  input  armPkg::memRspT fetchRsp,
  output armPkg::memReqT dataReq,
  input  armPkg::memRspT dataRsp
);
  import armPkg::*;

  logic [31:0] pcF;
  logic [31:0] pcNextF;
  logic [31:0] instrF;
  logic [31:0] instrBuf;
  logic [31:0] dataBuf;
  logic        fetchHave;
  logic        dataHave;
  decStageT    decQ;
  exeStageT    exeQ;
  memStageT    memQ;
  wbStageT     wbQ;
  ctrlT        ctrlD;
  ctrlT        ctrlGatedD;
  logic [31:0] pcPlus8D;
  logic [31:0] rd1D;
  logic [31:0] rd2D;
  logic [31:0] srcAE;
  logic [31:0] fwdBE;
  logic [31:0] srcBE;
  logic [31:0] aluOutE;
  logic [31:0] targetE;
  logic        memOpE;
  logic        branchTakenE;
  logic        memOpM;
  logic [31:0] resultW;
  logic        fetchWait;
  logic        dataWait;
  logic        stallF;
  logic        stallD;
  logic        stallE;
  logic        stallM;
  logic        stallW;
  logic        flushD;
  logic        flushE;
  logic [1:0]  forwardA;
  logic [1:0]  forwardB;

  // ==========================================================
  // Fetch
  // ==========================================================
  // A word fetched during a stall is parked until the next advance
  assign fetchReq  = '{valid: !fetchHave, write: 1'b0, addr: pcF, wdata: '0};
  assign fetchWait = !fetchHave && !fetchRsp.done;
  assign instrF    = fetchHave ? instrBuf : fetchRsp.rdata;
  assign pcNextF   = branchTakenE ? targetE : pcF + 32'd4;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF       <= pcReset;
      fetchHave <= 1'b0;
      dataHave  <= 1'b0;
    end else begin
      if (!stallF) begin
        pcF <= pcNextF;
      end
      if (!stallF) begin
        fetchHave <= 1'b0;
      end else if (fetchRsp.done) begin
        fetchHave <= 1'b1;
      end
      if (!stallM) begin
        dataHave <= 1'b0;
      end else if (dataRsp.done) begin
        dataHave <= 1'b1;
      end
    end
  end

  // Parked response words
  always_ff @(posedge clk) begin
    if (fetchRsp.done) begin
      instrBuf <= fetchRsp.rdata;
    end
    if (dataRsp.done) begin
      dataBuf <= dataRsp.rdata;
    end
  end

  // ==========================================================
  // Decode
  // ==========================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decQ <= '0;
    end else if (flushD) begin
      decQ <= '0;
    end else if (!stallD) begin
      decQ <= '{valid: 1'b1, pc: pcF, instr: instrT'(instrF)};
    end
  end

  controller i_controller (
    .instr (decQ.instr),
    .ctrl  (ctrlD)
  );

  // Bubbles must not write anything
  assign ctrlGatedD = decQ.valid ? ctrlD : '0;
  assign pcPlus8D   = decQ.pc + 32'd8;

  regFile i_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .we      (wbQ.valid && wbQ.ctrl.regWrite),
    .ra1     (ctrlD.rn),
    .ra2     (ctrlD.rm),
    .wa      (wbQ.ctrl.rd),
    .wd      (resultW),
    .pcPlus8 (pcPlus8D),
    .rd1     (rd1D),
    .rd2     (rd2D)
  );

  // ==========================================================
  // Execute
  // ==========================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exeQ <= '0;
    end else if (flushE) begin
      exeQ <= '0;
    end else if (!stallE) begin
      exeQ.valid   <= decQ.valid;
      exeQ.ctrl    <= ctrlGatedD;
      exeQ.pcPlus8 <= pcPlus8D;
      exeQ.rd1     <= rd1D;
      exeQ.rd2     <= rd2D;
      exeQ.imm24   <= decQ.instr[23:0];
    end
  end

  // Operand forwarding from M and W
  always_comb begin
    case (forwardA)
      fwdMem:  srcAE = memQ.aluOut;
      fwdWb:   srcAE = resultW;
      default: srcAE = exeQ.rd1;
    endcase
    case (forwardB)
      fwdMem:  fwdBE = memQ.aluOut;
      fwdWb:   fwdBE = resultW;
      default: fwdBE = exeQ.rd2;
    endcase
  end

  // Loads and stores add the plain 12-bit word offset
  assign memOpE = exeQ.ctrl.memWrite || exeQ.ctrl.memToReg;
  assign srcBE  = memOpE ? {20'h0, exeQ.imm24[11:0]} : fwdBE;

  alu i_alu (
    .a      (srcAE),
    .b      (srcBE),
    .op     (exeQ.ctrl.aluOp),
    .imm12  (exeQ.imm24[11:0]),
    .useImm (exeQ.ctrl.aluSrcImm),
    .y      (aluOutE)
  );

  assign branchTakenE = exeQ.valid && exeQ.ctrl.branch;
  assign targetE      = exeQ.pcPlus8 + {{6{exeQ.imm24[23]}}, exeQ.imm24, 2'b00};

  // ==========================================================
  // Memory and writeback
  // ==========================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memQ <= '0;
      wbQ  <= '0;
    end else begin
      if (!stallM) begin
        memQ <= '{valid: exeQ.valid, ctrl: exeQ.ctrl, aluOut: aluOutE, writeData: fwdBE};
      end
      if (!stallW) begin
        wbQ.valid    <= memQ.valid;
        wbQ.ctrl     <= memQ.ctrl;
        wbQ.aluOut   <= memQ.aluOut;
        wbQ.readData <= dataHave ? dataBuf : dataRsp.rdata;
      end
    end
  end

  // Request stays up until done, then drops while parked
  assign memOpM   = memQ.valid && (memQ.ctrl.memWrite || memQ.ctrl.memToReg);
  assign dataReq  = '{valid: memOpM && !dataHave, write: memQ.ctrl.memWrite,
                      addr: memQ.aluOut, wdata: memQ.writeData};
  assign dataWait = memOpM && !dataHave && !dataRsp.done;

  assign resultW = wbQ.ctrl.memToReg ? wbQ.readData : wbQ.aluOut;

  hazardUnit i_hazardUnit (
    .rnE          (exeQ.ctrl.rn),
    .rmE          (exeQ.ctrl.rm),
    .rdE          (exeQ.ctrl.rd),
    .memToRegE    (exeQ.ctrl.memToReg),
    .rdM          (memQ.ctrl.rd),
    .regWriteM    (memQ.ctrl.regWrite),
    .rdW          (wbQ.ctrl.rd),
    .regWriteW    (wbQ.ctrl.regWrite),
    .rnD          (ctrlGatedD.rn),
    .rmD          (ctrlGatedD.rm),
    .branchTakenE (branchTakenE),
    .fetchWait    (fetchWait),
    .dataWait     (dataWait),
    .stallF       (stallF),
    .stallD       (stallD),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushD       (flushD),
    .flushE       (flushE),
    .forwardA     (forwardA),
    .forwardB     (forwardB)
  );

endmodule

/* hdl/memArbiter.sv */
module memArbiter (
  input  logic           clk,
  input  logic           rstN,
  input  armPkg::memReqT fetchReq,
  output armPkg::memRspT fetchRsp,
  input  armPkg::memReqT dataReq,
  output armPkg::memRspT dataRsp,
  output armPkg::axiReqT axiReq,
  input  armPkg::axiRspT axiRsp
);
  import armPkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stAddr,
    stResp,
    stDone
  } stateT;

  stateT       state;
  memReqT      sel;
  logic        grantData;
  logic        arValid;
  logic        awValid;
  logic        wValid;
  logic        arPend;
  logic        awPend;
  logic        wPend;
  logic        curWrite;
  logic [31:0] curAddr;
  logic [31:0] curWdata;
  logic [31:0] rdataQ;

  // Data side has priority
  assign sel = dataReq.valid ? dataReq : fetchReq;

  // Channels still waiting for their ready
  assign arPend = arValid && !axiRsp.arready;
  assign awPend = awValid && !axiRsp.awready;
  assign wPend  = wValid && !axiRsp.wready;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= stIdle;
      grantData <= 1'b0;
      arValid   <= 1'b0;
      awValid   <= 1'b0;
      wValid    <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (sel.valid) begin
            grantData <= dataReq.valid;
            arValid   <= !sel.write;
            awValid   <= sel.write;
            wValid    <= sel.write;
            state     <= stAddr;
          end
        end
        stAddr: begin
          // AW and W may complete in either order
          arValid <= arPend;
          awValid <= awPend;
          wValid  <= wPend;
          if (!arPend && !awPend && !wPend) begin
            state <= stResp;
          end
        end
        stResp: begin
          if (curWrite ? axiRsp.bvalid : axiRsp.rvalid) begin
            state <= stDone;
          end
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

  // Transaction payload
  always_ff @(posedge clk) begin
    if (state == stIdle) begin
      curWrite <= sel.write;
      curAddr  <= sel.addr;
      curWdata <= sel.wdata;
    end
    if (state == stResp && axiRsp.rvalid) begin
      rdataQ <= axiRsp.rdata;
    end
  end

  always_comb begin
    axiReq         = '0;
    axiReq.arvalid = arValid;
    axiReq.araddr  = curAddr;
    axiReq.rready  = (state == stResp) && !curWrite;
    axiReq.awvalid = awValid;
    axiReq.awaddr  = curAddr;
    axiReq.wvalid  = wValid;
    axiReq.wdata   = curWdata;
    axiReq.wstrb   = 4'hf;
    axiReq.bready  = (state == stResp) && curWrite;
  end

  assign fetchRsp = '{done: (state == stDone) && !grantData, rdata: rdataQ};
  assign dataRsp  = '{done: (state == stDone) && grantData, rdata: rdataQ};

  // Read address held through slave back-pressure
  arHold: assert property (@(posedge clk) disable iff (!rstN)
    axiReq.arvalid && !axiRsp.arready |=> axiReq.arvalid);

  // Granted requester keeps its request up until done
  grantHeld: assert property (@(posedge clk) disable iff (!rstN)
    state != stIdle |-> (grantData ? dataReq.valid : fetchReq.valid));

  oneDone: assert property (@(posedge clk) disable iff (!rstN)
    !(fetchRsp.done && dataRsp.done));

endmodule

/* hdl/armCore.sv */
module armCore (
  input  logic           clk,
  input  logic           rstN,
  output armPkg::axiReqT axiReq,
  input  armPkg::axiRspT axiRsp
);
  import armPkg::*;

  // Requester links between pipeline and arbiter
  memReqT fetchReq;
  memRspT fetchRsp;
  memReqT dataReq;
  memRspT dataRsp;

  datapath i_datapath (
    .clk      (clk),
    .rstN     (rstN),
    .fetchReq (fetchReq),
    .fetchRsp (fetchRsp),
    .dataReq  (dataReq),
    .dataRsp  (dataRsp)
  );

  // Single AXI4-Lite port shared by fetch and data
  memArbiter i_memArbiter (
    .clk      (clk),
    .rstN     (rstN),
    .fetchReq (fetchReq),
    .fetchRsp (fetchRsp),
    .dataReq  (dataReq),
    .dataRsp  (dataRsp),
    .axiReq   (axiReq),
    .axiRsp   (axiRsp)
  );

endmodule

/* sim/axiLiteMem.sv */
module axiLiteMem (
  input  logic           clk,
  input  logic           rstN,
  input  armPkg::axiReqT axiReq,
  output armPkg::axiRspT axiRsp
);
  timeunit 1ns;
  timeprecision 1ps;
  import armPkg::*;

  // 4 KB as 1024 words, indexed by address bits 11 to 2
  logic [31:0] mem [1024];

  // Hand-encoded test program, loaded from address 0
  logic [31:0] prog [26] = '{
    32'hE3A0AB02,  // 00 MOV r10, #0x800
    32'hE3A01005,  // 04 MOV r1, #5
    32'hE2812C01,  // 08 ADD r2, r1, #0x100
    32'hE58A2000,  // 0C STR r2, [r10]
    32'hE24230FF,  // 10 SUB r3, r2, #0xFF
    32'hE2034003,  // 14 AND r4, r3, #3
    32'hE3845C02,  // 18 ORR r5, r4, #0x200
    32'hE58A3004,  // 1C STR r3, [r10, #4]
    32'hE58A4008,  // 20 STR r4, [r10, #8]
    32'hE58A500C,  // 24 STR r5, [r10, #12]
    32'hE0816001,  // 28 ADD r6, r1, r1
    32'hE3A07007,  // 2C MOV r7, #7
    32'hE0868007,  // 30 ADD r8, r6, r7
    32'hE58A8010,  // 34 STR r8, [r10, #16]
    32'hE59A9000,  // 38 LDR r9, [r10]
    32'hE2899001,  // 3C ADD r9, r9, #1
    32'hE58A9014,  // 40 STR r9, [r10, #20]
    32'hEA000001,  // 44 B 0x50
    32'hE58AA018,  // 48 STR r10, [r10, #24]  poison
    32'hE58AA01C,  // 4C STR r10, [r10, #28]  poison
    32'hE58A1018,  // 50 STR r1, [r10, #24]
    32'hE50A2004,  // 54 STR r2, [r10, #-4]
    32'hE50A3008,  // 58 STR r3, [r10, #-8]
    32'hE51AB004,  // 5C LDR r11, [r10, #-4]
    32'hE58AB01C,  // 60 STR r11, [r10, #28]
    32'hEAFFFFFE   // 64 B .
  };

  integer      seed = 32'hbefd;
  logic [1:0]  arDelay;
  logic [1:0]  rDelay;
  logic [1:0]  awDelay;
  logic [1:0]  wDelay;
  logic [1:0]  bDelay;
  logic        rPend;
  logic        awGot;
  logic        wGot;
  logic [31:0] rdAddr;
  logic [31:0] wrAddr;
  logic [31:0] wrData;

  // Latency of 0 to 3 cycles
  function automatic logic [1:0] latency();
    integer r;
    r = $random(seed);
    return r[1:0];
  endfunction

  initial begin
    // Fill depends on every address bit
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'hC0DE_0000 | (i << 2);
    end
    for (int i = 0; i < 26; i++) begin
      mem[i] = prog[i];
    end
  end

  // ==========================================================
  // Read and write channels with random delays
  // ==========================================================
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      axiRsp  <= '0;
      arDelay <= latency();
      awDelay <= latency();
      wDelay  <= latency();
      rDelay  <= '0;
      bDelay  <= '0;
      rPend   <= 1'b0;
      awGot   <= 1'b0;
      wGot    <= 1'b0;
    end else begin
      // AR ready pulses once, the master holds arvalid meanwhile
      if (axiRsp.arready) begin
        axiRsp.arready <= 1'b0;
        rdAddr         <= axiReq.araddr;
        rPend          <= 1'b1;
        rDelay         <= latency();
        arDelay        <= latency();
      end else if (axiReq.arvalid && !rPend && !axiRsp.rvalid) begin
        if (arDelay == 2'd0) begin
          axiRsp.arready <= 1'b1;
        end else begin
          arDelay <= arDelay - 2'd1;
        end
      end
      // R data held until rready
      if (axiRsp.rvalid && axiReq.rready) begin
        axiRsp.rvalid <= 1'b0;
      end else if (rPend) begin
        if (rDelay == 2'd0) begin
          axiRsp.rvalid <= 1'b1;
          axiRsp.rdata  <= mem[rdAddr[11:2]];
          axiRsp.rresp  <= 2'b00;
          rPend         <= 1'b0;
        end else begin
          rDelay <= rDelay - 2'd1;
        end
      end
      // AW channel
      if (axiRsp.awready) begin
        axiRsp.awready <= 1'b0;
        wrAddr         <= axiReq.awaddr;
        awGot          <= 1'b1;
        awDelay        <= latency();
        bDelay         <= latency();
      end else if (axiReq.awvalid && !awGot) begin
        if (awDelay == 2'd0) begin
          axiRsp.awready <= 1'b1;
        end else begin
          awDelay <= awDelay - 2'd1;
        end
      end
      // W channel, independent of AW
      if (axiRsp.wready) begin
        axiRsp.wready <= 1'b0;
        wrData        <= axiReq.wdata;
        wGot          <= 1'b1;
        wDelay        <= latency();
      end else if (axiReq.wvalid && !wGot) begin
        if (wDelay == 2'd0) begin
          axiRsp.wready <= 1'b1;
        end else begin
          wDelay <= wDelay - 2'd1;
        end
      end
      // B response once both halves arrived
      if (axiRsp.bvalid && axiReq.bready) begin
        axiRsp.bvalid <= 1'b0;
        awGot         <= 1'b0;
        wGot          <= 1'b0;
      end else if (awGot && wGot && !axiRsp.bvalid) begin
        if (bDelay == 2'd0) begin
          axiRsp.bvalid       <= 1'b1;
          axiRsp.bresp        <= 2'b00;
          mem[wrAddr[11:2]]   <= wrData;
        end else begin
          bDelay <= bDelay - 2'd1;
        end
      end
    end
  end

endmodule

/* sim/tbArmCore.sv */
module tbArmCore;
  timeunit 1ns;
  timeprecision 1ps;
  import armPkg::*;

  localparam int nStores = 10;
  localparam int maxIdle = 20000;

  logic   clk;
  logic   rstN;
  axiReqT axiReq;
  axiRspT axiRsp;
  int     storeIdx;
  logic   firstRead;
  int     idle;
  int     lastIdx;

  // Expected stores in program order with r10 at 0x800
  logic [31:0] expAddr [nStores] = '{
    32'h800, 32'h804, 32'h808, 32'h80C, 32'h810,
    32'h814, 32'h818, 32'h7FC, 32'h7F8, 32'h81C
  };
  // 5+0x100, 0x105-0xFF, 6&3, 2|0x200, 10+7, load+1, r1, r2, r3, reloaded r2
  logic [31:0] expData [nStores] = '{
    32'h105, 32'h006, 32'h002, 32'h202, 32'h011,
    32'h106, 32'h005, 32'h105, 32'h006, 32'h105
  };

  armCore i_armCore (
    .clk    (clk),
    .rstN   (rstN),
    .axiReq (axiReq),
    .axiRsp (axiRsp)
  );

  axiLiteMem i_axiLiteMem (
    .clk    (clk),
    .rstN   (rstN),
    .axiReq (axiReq),
    .axiRsp (axiRsp)
  );

  // ==========================================================
  // Clock and reset
  // ==========================================================
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin
    rstN = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
    end
    rstN <= 1'b1;
  end

  // ==========================================================
  // Checks
  // ==========================================================
  // Each completed write against the next table entry
  // Word stores only, so every byte lane is enabled
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      storeIdx <= 0;
    end else if (axiReq.bready && axiRsp.bvalid) begin
      storeCheck: assert (storeIdx < nStores && axiReq.awaddr == expAddr[storeIdx]
                          && axiReq.wdata == expData[storeIdx]
                          && axiReq.wstrb == 4'hf) begin
        storeIdx <= storeIdx + 1;
      end else begin
        $display("FAIL %0t: store %0d wrote %h to %h strobe %h, expected %h to %h", $time,
                 storeIdx, axiReq.wdata, axiReq.awaddr, axiReq.wstrb, expData[storeIdx],
                 expAddr[storeIdx]);
        $display("*** FAILED ***");
        $fatal(1, "Store mismatch");
      end
    end
  end

  // Bus quiet until the first fetch from address 0
  always @(posedge clk) begin
    if (!firstRead) begin
      resetQuiet: assert (!axiReq.awvalid && !axiReq.wvalid
                          && !axiReq.rready && !axiReq.bready
                          && (!axiReq.arvalid || axiReq.araddr == 32'h0)) begin
        if (axiReq.arvalid && axiRsp.arready) begin
          firstRead <= 1'b1;
        end
      end else begin
        $display("Bus activity seen before the first read of address 0");
        $display("*** FAILED ***");
        $fatal(1, "Early bus activity");
      end
    end
  end

  initial begin
    firstRead = 1'b0;
    idle      = 0;
    lastIdx   = 0;
    // Progress means another store accepted
    while (storeIdx < nStores && idle < maxIdle) begin
      @(posedge clk);
      if (storeIdx != lastIdx) begin
        idle = 0;
      end else begin
        idle++;
      end
      lastIdx = storeIdx;
    end
    if (storeIdx >= nStores) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "Timed out waiting for the next store");
    end
  end

endmodule

/* compile.f */
hdl/armPkg.sv
hdl/regFile.sv
hdl/alu.sv
hdl/controller.sv
hdl/hazardUnit.sv
hdl/datapath.sv
hdl/memArbiter.sv
hdl/armCore.sv
sim/axiLiteMem.sv
sim/tbArmCore.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tbArmCore -f compile.f -o VtbArmCore
	./obj_dir/VtbArmCore

clean:
	rm -rf obj_dir
